/* src/peConsts.svh */
/*
 * PE array constants
 * lane count, datapath and immediate widths, register file depth
 */

`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

//**************************************************************************
// array geometry
//**************************************************************************

`define PE_NUM_LANES 4           // lanes in the chain, lane 0 is leftmost

//**************************************************************************
// datapath
//**************************************************************************

`define PE_DATA_WIDTH 16         // lane data word

`define PE_IMM_WIDTH 8           // instruction immediate, sign-extended

// register file, depth and index must agree
`define PE_RF_DEPTH 4
`define PE_RF_INDEX_WIDTH 2

`endif

/* src/pePkg.sv */
/*
 * PE array types
 * opcodes, result sources, ALU operations, boundary modes and the
 * instruction, broadcast control and configuration structs
 */

`include "peConsts.svh"

package pePkg;

  typedef logic [`PE_DATA_WIDTH-1:0] peDataT;  // one lane word

  //**************************************************************************
  // instruction encoding
  //**************************************************************************

  typedef enum logic [2:0] {
    OP_NOP = 3'd0,  // no write
    OP_LDI = 3'd1,  // rd = sext(imm)
    OP_LID = 3'd2,  // rd = lane index
    OP_ADD = 3'd3,  // rd = ra + rb
    OP_SUB = 3'd4,  // rd = ra - rb
    OP_XOR = 3'd5,  // rd = ra ^ rb
    OP_MVL = 3'd6,  // rd = left neighbour ra
    OP_MVR = 3'd7   // rd = right neighbour ra
  } peOpcodeE;

  typedef struct packed {
    peOpcodeE                      opcode;
    logic [`PE_RF_INDEX_WIDTH-1:0] rd;
    logic [`PE_RF_INDEX_WIDTH-1:0] ra;
    logic [`PE_RF_INDEX_WIDTH-1:0] rb;
    logic [`PE_IMM_WIDTH-1:0]      imm;
  } peInsT;

  //**************************************************************************
  // broadcast control
  //**************************************************************************

  // write-back value select
  typedef enum logic [2:0] {
    SRC_ALU   = 3'd0,
    SRC_IMM   = 3'd1,
    SRC_LANE  = 3'd2,
    SRC_LEFT  = 3'd3,
    SRC_RIGHT = 3'd4
  } resultSrcE;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_XOR = 2'd2
  } aluOpE;

  typedef struct packed {
    logic                          writeEnable;  // valid instruction this cycle
    resultSrcE                     src;
    aluOpE                         aluOp;
    logic [`PE_RF_INDEX_WIDTH-1:0] rd;
    logic [`PE_RF_INDEX_WIDTH-1:0] ra;
    logic [`PE_RF_INDEX_WIDTH-1:0] rb;
    peDataT                        imm;          // already sign-extended
  } peCtrlT;

  // edge lane neighbour source, same code for both ends
  typedef enum logic [1:0] {
    BND_ZERO   = 2'd0,
    BND_SCALAR = 2'd1,
    BND_WRAP   = 2'd2,
    BND_SELF   = 2'd3
  } boundaryModeE;

  typedef struct packed {
    boundaryModeE firstMode;  // left input of lane 0
    boundaryModeE lastMode;   // right input of last lane
    peDataT       scalar;     // control processor value
  } arrayCfgT;

endpackage

/* src/broadcastDecode.sv */
/*
 * Broadcast decode
 * two-stage front end shared by all lanes. Stage one captures the
 * strobed instruction, stage two decodes it into the control word
 * that every lane executes in lockstep.
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module broadcastDecode (
  input  logic           clk,
  input  logic           rstN,
  input  logic           insValid,  // one-cycle strobe, no back-pressure
  input  pePkg::peInsT   ins,
  output pePkg::peCtrlT  ctrl       // to every lane
);

  import pePkg::*;

  logic   fetchValid;
  peInsT  fetchIns;
  peCtrlT ctrlNext;

  //**************************************************************************
  // fetch stage
  //**************************************************************************

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchValid <= 1'b0;
    end else begin
      fetchValid <= insValid;
    end
  end

  always_ff @(posedge clk) begin
    if (insValid) begin
      fetchIns <= ins;  // held while idle
    end
  end

  //**************************************************************************
  // decode stage
  //**************************************************************************

  always_comb begin
    ctrlNext.writeEnable = fetchValid;
    ctrlNext.src         = SRC_ALU;
    ctrlNext.aluOp       = ALU_ADD;
    ctrlNext.rd          = fetchIns.rd;
    ctrlNext.ra          = fetchIns.ra;
    ctrlNext.rb          = fetchIns.rb;
    // sign-extend imm to lane width
    ctrlNext.imm = {{(`PE_DATA_WIDTH - `PE_IMM_WIDTH){fetchIns.imm[`PE_IMM_WIDTH-1]}},
                    fetchIns.imm};
    case (fetchIns.opcode)
      OP_NOP: ctrlNext.writeEnable = 1'b0;  // nothing written
      OP_LDI: ctrlNext.src = SRC_IMM;
      OP_LID: ctrlNext.src = SRC_LANE;
      OP_ADD: ctrlNext.aluOp = ALU_ADD;
      OP_SUB: ctrlNext.aluOp = ALU_SUB;
      OP_XOR: ctrlNext.aluOp = ALU_XOR;
      OP_MVL: ctrlNext.src = SRC_LEFT;
      OP_MVR: ctrlNext.src = SRC_RIGHT;
      default: ctrlNext.writeEnable = 1'b0;
    endcase
  end

  // whole word cleared so lanes see a clean NOP out of reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrl <= '0;
    end else begin
      ctrl <= ctrlNext;
    end
  end

endmodule

/* src/boundaryControl.sv */
/*
 * Boundary control
 * holds the array configuration and picks what the edge lanes see
 * in place of their missing neighbour: zero, the control processor
 * scalar, the opposite end lane, or the lane itself.
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module boundaryControl (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cfgWrite,       // one-cycle load strobe
  input  pePkg::arrayCfgT  cfg,
  input  pePkg::peDataT    firstPortData,  // lane 0 ra
  input  pePkg::peDataT    lastPortData,   // last lane ra
  output pePkg::peDataT    firstLeftData,
  output pePkg::peDataT    lastRightData
);

  import pePkg::*;

  arrayCfgT cfgReg;

  // one rule for both ends, only own and opposite swap
  function automatic peDataT selectBoundary(
    input boundaryModeE mode,
    input peDataT       ownData,
    input peDataT       oppositeData,
    input peDataT       scalar
  );
    case (mode)
      BND_ZERO:   return '0;
      BND_SCALAR: return scalar;
      BND_WRAP:   return oppositeData;  // ring
      BND_SELF:   return ownData;       // mirror
      default:    return '0;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cfgReg <= '{firstMode: BND_ZERO, lastMode: BND_ZERO, scalar: '0};
    end else if (cfgWrite) begin
      cfgReg <= cfg;
    end
  end

  // combinational from port data, no extra cycle
  assign firstLeftData = selectBoundary(cfgReg.firstMode, firstPortData, lastPortData,
                                        cfgReg.scalar);
  assign lastRightData = selectBoundary(cfgReg.lastMode, lastPortData, firstPortData,
                                        cfgReg.scalar);

endmodule

/* src/laneRegFile.sv */
/*
 * Lane register file
 * two combinational read ports, one write port taken at the clock
 * edge, all registers cleared by reset
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module laneRegFile (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          writeEnable,
  input  logic [`PE_RF_INDEX_WIDTH-1:0] writeAddr,
  input  logic [`PE_RF_INDEX_WIDTH-1:0] readAddrA,
  input  logic [`PE_RF_INDEX_WIDTH-1:0] readAddrB,
  input  logic [`PE_DATA_WIDTH-1:0]     writeData,
  output logic [`PE_DATA_WIDTH-1:0]     readDataA,
  output logic [`PE_DATA_WIDTH-1:0]     readDataB
);

  logic [`PE_DATA_WIDTH-1:0] regs [`PE_RF_DEPTH];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `PE_RF_DEPTH; i++) begin
        regs[i] <= '0;  // architectural state starts at zero
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  // reads see the old value during a write cycle
  // no bypass needed, the next instruction reads after the edge
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

/* src/peLane.sv */
/*
 * Processing element lane
 * reads ra and rb from its own register file, runs the ALU, selects
 * the write-back value among ALU, immediate, lane index and the two
 * neighbours, then writes rd and registers the result.
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module peLane #(
  parameter int laneId = 0  // value written by LID
) (
  input  logic           clk,
  input  logic           rstN,
  input  pePkg::peCtrlT  ctrl,         // broadcast control
  input  pePkg::peDataT  leftData,     // left neighbour ra or boundary
  input  pePkg::peDataT  rightData,    // right neighbour ra or boundary
  output pePkg::peDataT  portData,     // own ra, to neighbours
  output pePkg::peDataT  laneResult,
  output logic           resultValid
);

  import pePkg::*;

  peDataT opA;
  peDataT opB;
  peDataT aluResult;
  peDataT writeValue;

  //**************************************************************************
  // operand read
  //**************************************************************************

  laneRegFile uRegFile (
    .clk         (clk),
    .rstN        (rstN),
    .writeEnable (ctrl.writeEnable),
    .writeAddr   (ctrl.rd),
    .readAddrA   (ctrl.ra),
    .readAddrB   (ctrl.rb),
    .writeData   (writeValue),
    .readDataA   (opA),
    .readDataB   (opB)
  );

  assign portData = opA;  // same port feeds MVL/MVR of both neighbours

  //**************************************************************************
  // execute
  //**************************************************************************

  // wraps modulo 2^16, no flags
  always_comb begin
    case (ctrl.aluOp)
      ALU_ADD: aluResult = opA + opB;
      ALU_SUB: aluResult = opA - opB;
      ALU_XOR: aluResult = opA ^ opB;
      default: aluResult = opA + opB;
    endcase
  end

  always_comb begin
    case (ctrl.src)
      SRC_ALU:   writeValue = aluResult;
      SRC_IMM:   writeValue = ctrl.imm;          // sign-extended in decode
      SRC_LANE:  writeValue = peDataT'(laneId);
      SRC_LEFT:  writeValue = leftData;
      SRC_RIGHT: writeValue = rightData;
      default:   writeValue = aluResult;
    endcase
  end

  //**************************************************************************
  // result register
  //**************************************************************************

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= ctrl.writeEnable;  // one cycle, mirrors the rd write
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.writeEnable) begin
      laneResult <= writeValue;  // same value that went to rd
    end
  end

endmodule

/* src/peArrayTop.sv */
/*
 * PE array top
 * one decoder broadcasting to a chain of lanes. Each lane sees its
 * neighbours' ra port; the two edge lanes get their outer neighbour
 * from the boundary control.
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module peArrayTop (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic                                  insValid,
  input  pePkg::peInsT                          ins,
  input  logic                                  cfgWrite,
  input  pePkg::arrayCfgT                       cfg,
  output logic                                  resultValid,
  output pePkg::peDataT [`PE_NUM_LANES-1:0]     laneResult
);

  import pePkg::*;

  peCtrlT                      ctrl;            // broadcast
  peDataT [`PE_NUM_LANES-1:0]  portData;        // per-lane ra
  peDataT [`PE_NUM_LANES-1:0]  leftIn;
  peDataT [`PE_NUM_LANES-1:0]  rightIn;
  logic   [`PE_NUM_LANES-1:0]  laneValid;
  peDataT                      firstLeftData;
  peDataT                      lastRightData;

  //**************************************************************************
  // shared front end
  //**************************************************************************

  broadcastDecode uDecode (
    .clk      (clk),
    .rstN     (rstN),
    .insValid (insValid),
    .ins      (ins),
    .ctrl     (ctrl)
  );

  boundaryControl uBoundary (
    .clk           (clk),
    .rstN          (rstN),
    .cfgWrite      (cfgWrite),
    .cfg           (cfg),
    .firstPortData (portData[0]),
    .lastPortData  (portData[`PE_NUM_LANES-1]),
    .firstLeftData (firstLeftData),
    .lastRightData (lastRightData)
  );

  //**************************************************************************
  // lane chain
  //**************************************************************************

  for (genvar i = 0; i < `PE_NUM_LANES; i++) begin : gLane
    if (i == 0) begin : gLeftEdge
      assign leftIn[i] = firstLeftData;
    end else begin : gLeftLink
      assign leftIn[i] = portData[i-1];
    end
    if (i == `PE_NUM_LANES - 1) begin : gRightEdge
      assign rightIn[i] = lastRightData;
    end else begin : gRightLink
      assign rightIn[i] = portData[i+1];
    end

    peLane #(
      .laneId (i)
    ) uLane (
      .clk         (clk),
      .rstN        (rstN),
      .ctrl        (ctrl),
      .leftData    (leftIn[i]),
      .rightData   (rightIn[i]),
      .portData    (portData[i]),
      .laneResult  (laneResult[i]),
      .resultValid (laneValid[i])
    );
  end

  assign resultValid = laneValid[0];  // lanes run in lockstep

endmodule

/* dv/peArrayTb.sv */
/*
 * PE array testbench
 * drives strobed instructions and configuration writes into the array,
 * predicts every lane result with a reference model at issue time and
 * checks results and valid timing with assertions
 */

`timescale 1ns/1ps
`include "peConsts.svh"

module peArrayTb;

  import pePkg::*;

  localparam time clkPeriod  = 100;
  localparam time driveDelay = 5;        // after the rising edge
  localparam int  numAlu     = 24;       // random ALU ops in test 2
  localparam int  numChain   = 8;        // dependent ops in test 5
  localparam int  insCount   = 2 + (4 + numAlu) + 3 + 11 + (2 + numChain) + 6;
  localparam int  drainLimit = 10;       // cycles to wait for the queue to empty

  logic                              clk = 1'b0;
  logic                              rstN;
  logic                              insValid;
  peInsT                             ins;
  logic                              cfgWrite;
  arrayCfgT                          cfg;
  logic                              resultValid;
  peDataT [`PE_NUM_LANES-1:0]        laneResult;
  logic                              writeStrobe;

  peDataT   modelRegs [`PE_NUM_LANES][`PE_RF_DEPTH];  // per-lane register copy
  arrayCfgT modelCfg;
  peDataT [`PE_NUM_LANES-1:0] expQ [$];               // one entry per write

  peArrayTop dut (
    .clk         (clk),
    .rstN        (rstN),
    .insValid    (insValid),
    .ins         (ins),
    .cfgWrite    (cfgWrite),
    .cfg         (cfg),
    .resultValid (resultValid),
    .laneResult  (laneResult)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  //**************************************************************************
  // reference model
  //**************************************************************************

  // value a lane receives from one side, edge lanes follow the boundary mode
  function automatic peDataT neighbourValue(input int lane, input bit fromLeft,
                                            input logic [`PE_RF_INDEX_WIDTH-1:0] ra);
    int           src;
    boundaryModeE mode;
    src = fromLeft ? lane - 1 : lane + 1;
    if (src >= 0 && src < `PE_NUM_LANES) return modelRegs[src][ra];
    mode = fromLeft ? modelCfg.firstMode : modelCfg.lastMode;
    case (mode)
      BND_ZERO:   return '0;
      BND_SCALAR: return modelCfg.scalar;
      BND_WRAP:   return modelRegs[(src + `PE_NUM_LANES) % `PE_NUM_LANES][ra];  // far end
      default:    return modelRegs[lane][ra];                // self
    endcase
  endfunction

  task automatic modelExec(input peInsT insn);
    peDataT [`PE_NUM_LANES-1:0] result;
    peDataT                     immExt;
    immExt = peDataT'($signed(insn.imm));  // sign extension by cast
    if (insn.opcode == OP_NOP) return;
    // all lanes read old state before any lane writes
    for (int i = 0; i < `PE_NUM_LANES; i++) begin
      case (insn.opcode)
        OP_LDI:  result[i] = immExt;
        OP_LID:  result[i] = peDataT'(i);
        OP_ADD:  result[i] = modelRegs[i][insn.ra] + modelRegs[i][insn.rb];
        OP_SUB:  result[i] = modelRegs[i][insn.ra] - modelRegs[i][insn.rb];
        OP_XOR:  result[i] = modelRegs[i][insn.ra] ^ modelRegs[i][insn.rb];
        OP_MVL:  result[i] = neighbourValue(i, 1'b1, insn.ra);
        OP_MVR:  result[i] = neighbourValue(i, 1'b0, insn.ra);
        default: result[i] = '0;
      endcase
    end
    for (int i = 0; i < `PE_NUM_LANES; i++) modelRegs[i][insn.rd] = result[i];
    expQ.push_back(result);
  endtask

  //**************************************************************************
  // drive tasks
  //**************************************************************************

  // leaves insValid high, the next drive task takes it down
  task automatic issue(input peOpcodeE op, input logic [1:0] rdIdx, input logic [1:0] raIdx,
                       input logic [1:0] rbIdx, input logic [7:0] immVal);
    peInsT insn;
    insn.opcode = op;
    insn.rd     = rdIdx;
    insn.ra     = raIdx;
    insn.rb     = rbIdx;
    insn.imm    = immVal;
    @(posedge clk);
    #driveDelay;
    insValid = 1'b1;
    ins      = insn;
    cfgWrite = 1'b0;
    modelExec(insn);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #driveDelay;
      insValid = 1'b0;
      cfgWrite = 1'b0;
    end
  endtask

  task automatic configure(input boundaryModeE firstMode, input boundaryModeE lastMode,
                           input peDataT scalar);
    @(posedge clk);
    #driveDelay;
    insValid       = 1'b0;
    cfgWrite       = 1'b1;
    cfg.firstMode  = firstMode;
    cfg.lastMode   = lastMode;
    cfg.scalar     = scalar;
    modelCfg       = cfg;  // applies to everything issued from now on
  endtask

  // stop driving and wait for every predicted result
  task automatic drain();
    int waitCount;
    waitCount = 0;
    idle(1);
    while (expQ.size() != 0 && waitCount < drainLimit) begin
      @(negedge clk);
      waitCount++;
    end
    if (expQ.size() != 0) failRun("results still missing after the pipeline drained");
  endtask

  //**************************************************************************
  // checks
  //**************************************************************************

  assign writeStrobe = insValid && (ins.opcode != OP_NOP);

  // registered 2 cycles after the strobe edge, so seen at the third edge
  validTiming: assert property (@(posedge clk) disable iff (!rstN)
      resultValid == $past(writeStrobe, 3))
    else failRun($sformatf("CHECK FAILED t=%0t resultValid got %b expected %b",
                           $time, $sampled(resultValid), !$sampled(resultValid)));

  always @(negedge clk) begin
    peDataT [`PE_NUM_LANES-1:0] expected;
    if (rstN && resultValid) begin
      if (expQ.size() == 0) begin
        failRun($sformatf("resultValid high at %0t with no result pending", $time));
      end else begin
        expected = expQ.pop_front();
        for (int i = 0; i < `PE_NUM_LANES; i++) begin
          resultMatch: assert (laneResult[i] == expected[i])
            else failRun($sformatf("CHECK FAILED t=%0t laneResult[%0d] got %h expected %h",
                                   $time, i, laneResult[i], expected[i]));
        end
      end
    end
  end

  initial begin
    #((insCount + 50) * clkPeriod);
    failRun("timeout, the tests did not finish in time");
  end

  //**************************************************************************
  // stimulus
  //**************************************************************************

  initial begin
    int prev;
    int rdNext;
    void'($urandom(32'h8d6f));
    rstN     = 1'b0;
    insValid = 1'b0;
    ins      = '0;
    cfgWrite = 1'b0;
    cfg      = '0;
    for (int i = 0; i < `PE_NUM_LANES; i++)
      for (int r = 0; r < `PE_RF_DEPTH; r++) modelRegs[i][r] = '0;
    modelCfg = '{firstMode: BND_ZERO, lastMode: BND_ZERO, scalar: '0};
    repeat (4) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;

    // test 1, zero registers then lane index
    issue(OP_ADD, 2'd1, 2'd0, 2'd0, 8'h00);
    issue(OP_LID, 2'd2, 2'd0, 2'd0, 8'h00);
    drain();

    // test 2, loads with both signs then random ALU ops
    issue(OP_LDI, 2'd0, 2'd0, 2'd0, {1'b0, 7'($urandom)});
    issue(OP_LDI, 2'd1, 2'd0, 2'd0, 8'($urandom));
    issue(OP_LDI, 2'd2, 2'd0, 2'd0, 8'($urandom));
    issue(OP_LDI, 2'd3, 2'd0, 2'd0, {1'b1, 7'($urandom)});  // negative
    for (int k = 0; k < numAlu; k++) begin
      case ($urandom_range(2))
        0:       issue(OP_ADD, 2'($urandom), 2'($urandom), 2'($urandom), 8'($urandom));
        1:       issue(OP_SUB, 2'($urandom), 2'($urandom), 2'($urandom), 8'($urandom));
        default: issue(OP_XOR, 2'($urandom), 2'($urandom), 2'($urandom), 8'($urandom));
      endcase
    end
    drain();

    // test 3, interior neighbour moves over distinct lane values
    issue(OP_LID, 2'd0, 2'd0, 2'd0, 8'h00);
    issue(OP_MVL, 2'd1, 2'd0, 2'd0, 8'h00);
    issue(OP_MVR, 2'd2, 2'd0, 2'd0, 8'h00);

    // test 4, every boundary mode at each end, lanes hold 0x41 + index
    issue(OP_LID, 2'd3, 2'd0, 2'd0, 8'h00);
    issue(OP_LDI, 2'd2, 2'd0, 2'd0, 8'h41);
    issue(OP_ADD, 2'd3, 2'd3, 2'd2, 8'h00);
    for (int m = 0; m < 4; m++) begin
      idle(1);  // last move executes under the old mode
      configure(boundaryModeE'(m), boundaryModeE'(3 - m), 16'($urandom));
      issue(OP_MVL, 2'd1, 2'd3, 2'd0, 8'h00);
      issue(OP_MVR, 2'd2, 2'd3, 2'd0, 8'h00);
    end
    drain();

    // test 5, back to back, each op reads the previous rd
    issue(OP_LDI, 2'd0, 2'd0, 2'd0, 8'h7f);
    issue(OP_LDI, 2'd1, 2'd0, 2'd0, 8'h85);
    prev = 1;
    for (int k = 0; k < numChain; k++) begin
      rdNext = (prev + 1) % `PE_RF_DEPTH;
      case (k % 3)
        0:       issue(OP_ADD, 2'(rdNext), 2'(prev), 2'((prev + 3) % 4), 8'h00);
        1:       issue(OP_SUB, 2'(rdNext), 2'(prev), 2'((prev + 3) % 4), 8'h00);
        default: issue(OP_XOR, 2'(rdNext), 2'(prev), 2'((prev + 3) % 4), 8'h00);
      endcase
      prev = rdNext;
    end
    drain();

    // test 6, NOPs with random fields and idle gaps, then read back all four
    repeat (3) issue(OP_NOP, 2'($urandom), 2'($urandom), 2'($urandom), 8'($urandom));
    idle(4);
    issue(OP_NOP, 2'($urandom), 2'($urandom), 2'($urandom), 8'($urandom));
    issue(OP_ADD, 2'd0, 2'd0, 2'd1, 8'h00);
    issue(OP_SUB, 2'd1, 2'd3, 2'd2, 8'h00);
    drain();

    $display("No errors");
    $finish;
  end

endmodule

/* all.f */
+incdir+src
src/pePkg.sv
src/broadcastDecode.sv
src/boundaryControl.sv
src/laneRegFile.sv
src/peLane.sv
src/peArrayTop.sv
dv/peArrayTb.sv

/* run.sh */
#!/bin/sh
# build the PE array testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module peArrayTb -f all.f -o peArraySim &&
{ ./obj_dir/peArraySim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "No errors" sim.log ||
{ echo "simulation FAILED"; exit 1; }
echo "simulation passed"
